//--- hw/load_pkg.sv
/*
  Shared widths, types and load opcodes of the load path.
  Physical address equals virtual address, so there is no translation.
  Only the integer loads LD, LW, LWU, LH, LHU, LB and LBU are known.
  The 12-bit cache index doubles as the page offset for store checks.
*/
package load_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------
  localparam int unsigned XLEN       = 64;
  localparam int unsigned ADDR_W     = 32;
  // index covers one 4 KiB page
  localparam int unsigned INDEX_W    = 12;
  // tag is everything above the index
  localparam int unsigned TAG_W      = ADDR_W - INDEX_W;
  // byte position inside one doubleword
  localparam int unsigned OFFSET_W   = 3;
  localparam int unsigned TRANS_ID_W = 3;
  // outstanding loads towards the cache
  localparam int unsigned NR_LDBUF   = 4;
  localparam int unsigned LDBUF_ID_W = 2;

  // ----------------------------------------
  // plain vector types
  // ----------------------------------------
  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [INDEX_W-1:0]    index_t;
  typedef logic [TAG_W-1:0]      tag_t;
  typedef logic [OFFSET_W-1:0]   offset_t;
  typedef logic [TRANS_ID_W-1:0] trans_id_t;
  typedef logic [LDBUF_ID_W-1:0] ldbuf_id_t;
  // 0 byte, 1 half, 2 word, 3 doubleword
  typedef logic [1:0]            size_t;
  typedef logic [2:0]            load_op_t;

  // load opcodes
  localparam load_op_t OP_LD  = 3'd0;
  localparam load_op_t OP_LW  = 3'd1;
  localparam load_op_t OP_LWU = 3'd2;
  localparam load_op_t OP_LH  = 3'd3;
  localparam load_op_t OP_LHU = 3'd4;
  localparam load_op_t OP_LB  = 3'd5;
  localparam load_op_t OP_LBU = 3'd6;

  // request FSM of the load controller
  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT,
    SEND_TAG,
    WAIT_PAGE_OFFSET,
    WAIT_FLUSH
  } ld_state_e;

  // ----------------------------------------
  // size of the cache access for an opcode
  // ----------------------------------------
  function automatic size_t transfer_size(load_op_t op);
    case (op)
      OP_LD:          return 2'd3;
      OP_LW, OP_LWU:  return 2'd2;
      OP_LH, OP_LHU:  return 2'd1;
      // byte loads and unused codes
      default:        return 2'd0;
    endcase
  endfunction

endpackage

//--- hw/load_ctrl.sv
/*
  Request FSM towards the data cache.
  valid_i and its fields must hold steady until pop_ld_o.
  A flush in any state spends one cycle in WAIT_FLUSH with kill and tag valid.
  A load accepted in SEND_TAG overlaps its index phase with the tag phase.
*/
module load_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  // load from the issue stage
  input  logic                 valid_i,
  input  load_pkg::addr_t      vaddr_i,
  input  load_pkg::load_op_t   op_i,
  // store offset conflict and cache grant
  input  logic                 page_offset_matches_i,
  input  logic                 data_gnt_i,
  // back-pressure from the load buffer
  input  logic                 ldbuf_full_i,
  // index phase
  output logic                 data_req_o,
  output load_pkg::index_t     addr_index_o,
  output load_pkg::size_t      data_size_o,
  // tag phase
  output load_pkg::tag_t       addr_tag_o,
  output logic                 tag_valid_o,
  output logic                 kill_req_o,
  // handshakes
  output logic                 pop_ld_o,
  output logic                 ldbuf_we_o
);

  load_pkg::ld_state_e state_d, state_q;
  load_pkg::tag_t      tag_q;
  logic                accept;

  // index and size come straight from the pending load
  assign addr_index_o = vaddr_i[load_pkg::INDEX_W-1:0];
  assign data_size_o  = load_pkg::transfer_size(op_i);

  // new load only with room for its response
  assign accept = valid_i & ~ldbuf_full_i;

  // a granted request is tracked in the buffer
  assign ldbuf_we_o = data_req_o & data_gnt_i;

  // ----------------------------------------
  // request FSM
  // ----------------------------------------
  always_comb begin
    state_d     = state_q;
    data_req_o  = 1'b0;
    tag_valid_o = 1'b0;
    kill_req_o  = 1'b0;
    pop_ld_o    = 1'b0;

    case (state_q)
      // IDLE and SEND_TAG share the accept path
      load_pkg::IDLE,
      load_pkg::SEND_TAG: begin
        // tag of the load granted last cycle
        tag_valid_o = (state_q == load_pkg::SEND_TAG);
        state_d     = load_pkg::IDLE;
        if (accept) begin
          if (!page_offset_matches_i) begin
            data_req_o = 1'b1;
            if (data_gnt_i) begin
              // granted at once, tag follows next cycle
              pop_ld_o = 1'b1;
              state_d  = load_pkg::SEND_TAG;
            end else begin
              state_d = load_pkg::WAIT_GNT;
            end
          end else begin
            // a store to the same offset is still pending
            state_d = load_pkg::WAIT_PAGE_OFFSET;
          end
        end
      end

      // keep asking until the cache takes the request
      load_pkg::WAIT_GNT: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          pop_ld_o = 1'b1;
          state_d  = load_pkg::SEND_TAG;
        end
      end

      // stall until the store unit clears the conflict
      load_pkg::WAIT_PAGE_OFFSET: begin
        if (!page_offset_matches_i) begin
          state_d = load_pkg::WAIT_GNT;
        end
      end

      // kill whatever sits in the tag phase
      load_pkg::WAIT_FLUSH: begin
        kill_req_o  = 1'b1;
        tag_valid_o = 1'b1;
        state_d     = load_pkg::IDLE;
      end

      default: begin
        state_d = load_pkg::IDLE;
      end
    endcase

    // flush wins over every state
    if (flush_i) begin
      state_d = load_pkg::WAIT_FLUSH;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= load_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ----------------------------------------
  // tag register
  // ----------------------------------------
  // captured on the grant, shown in the following cycle
  always_ff @(posedge clk_i) begin
    if (ldbuf_we_o) begin
      tag_q <= vaddr_i[load_pkg::ADDR_W-1:load_pkg::INDEX_W];
    end
  end

  assign addr_tag_o = tag_q;

endmodule

//--- hw/load_buffer.sv
/*
  Table of outstanding loads, indexed by the cache request id.
  The lowest free entry is offered as the id of the next request.
  A flush marks all entries, including one written in the same cycle.
  Responses to flushed entries free the slot but give no valid_o.
*/
module load_buffer (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  // write side, on a granted request
  input  logic                 we_i,
  input  load_pkg::trans_id_t  trans_id_i,
  input  load_pkg::offset_t    offset_i,
  input  load_pkg::load_op_t   op_i,
  // response side
  input  logic                 rvalid_i,
  input  load_pkg::ldbuf_id_t  rid_i,
  // status
  output logic                 full_o,
  output load_pkg::ldbuf_id_t  wid_o,
  // entry of the returning response
  output logic                 valid_o,
  output load_pkg::trans_id_t  trans_id_o,
  output load_pkg::offset_t    rd_offset_o,
  output load_pkg::load_op_t   rd_op_o
);

  logic [load_pkg::NR_LDBUF-1:0] valid_d, valid_q;
  logic [load_pkg::NR_LDBUF-1:0] flushed_d, flushed_q;

  // payload per entry
  load_pkg::trans_id_t id_q  [load_pkg::NR_LDBUF];
  load_pkg::offset_t   off_q [load_pkg::NR_LDBUF];
  load_pkg::load_op_t  op_q  [load_pkg::NR_LDBUF];

  load_pkg::ldbuf_id_t free_idx;

  // ----------------------------------------
  // free slot search
  // ----------------------------------------
  // scan from the top, the last free hit is the lowest one
  always_comb begin
    free_idx = '0;
    for (int i = load_pkg::NR_LDBUF - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        free_idx = load_pkg::ldbuf_id_t'(i);
      end
    end
  end

  assign wid_o  = free_idx;
  // no free slot left, controller holds off
  assign full_o = &valid_q;

  // ----------------------------------------
  // valid and flushed flags
  // ----------------------------------------
  always_comb begin
    valid_d   = valid_q;
    flushed_d = flushed_q;
    // response retires its entry
    if (rvalid_i) begin
      valid_d[rid_i] = 1'b0;
    end
    // new entry starts clean
    if (we_i) begin
      valid_d[free_idx]   = 1'b1;
      flushed_d[free_idx] = 1'b0;
    end
    // applied last so it also covers the entry written now
    if (flush_i) begin
      flushed_d = '1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= '0;
      flushed_q <= '0;
    end else begin
      valid_q   <= valid_d;
      flushed_q <= flushed_d;
    end
  end

  // payload write
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      id_q[free_idx]  <= trans_id_i;
      off_q[free_idx] <= offset_i;
      op_q[free_idx]  <= op_i;
    end
  end

  // ----------------------------------------
  // response lookup
  // ----------------------------------------
  // read in the cycle the response arrives
  assign trans_id_o  = id_q[rid_i];
  assign rd_offset_o = off_q[rid_i];
  assign rd_op_o     = op_q[rid_i];

  // only live, unflushed entries produce a result
  assign valid_o = rvalid_i & valid_q[rid_i] & ~flushed_q[rid_i];

endmodule

//--- hw/load_align.sv
/*
  Realigns the returned doubleword and extends it by opcode.
  Purely combinational. Offsets must keep the field inside the doubleword.
  The sign bit is picked from the raw data in parallel with the shift.
*/
module load_align (
  input  load_pkg::xlen_t     rdata_i,
  input  load_pkg::offset_t   offset_i,
  input  load_pkg::load_op_t  op_i,
  output load_pkg::xlen_t     result_o
);

  localparam int unsigned NR_BYTES = load_pkg::XLEN / 8;

  load_pkg::xlen_t         shifted;
  logic [NR_BYTES-1:0]     sign_bits;
  load_pkg::offset_t       sign_idx;
  logic                    is_signed;
  logic                    sign_bit;

  // move the addressed byte down to bit 0
  assign shifted = rdata_i >> {offset_i, 3'b000};

  // ----------------------------------------
  // parallel sign selection
  // ----------------------------------------
  // top bit of every byte lane
  for (genvar i = 0; i < NR_BYTES; i++) begin : gen_sign_bits
    assign sign_bits[i] = rdata_i[i*8+7];
  end

  // lane holding the last byte of the loaded field
  always_comb begin
    case (op_i)
      load_pkg::OP_LW: sign_idx = offset_i + 3'd3;
      load_pkg::OP_LH: sign_idx = offset_i + 3'd1;
      default:         sign_idx = offset_i;
    endcase
  end

  assign is_signed = (op_i == load_pkg::OP_LW) ||
                     (op_i == load_pkg::OP_LH) ||
                     (op_i == load_pkg::OP_LB);

  // unsigned loads pull the fill to zero
  assign sign_bit = is_signed & sign_bits[sign_idx];

  // ----------------------------------------
  // result mux
  // ----------------------------------------
  always_comb begin
    case (op_i)
      load_pkg::OP_LW, load_pkg::OP_LWU:
        result_o = {{(load_pkg::XLEN-32){sign_bit}}, shifted[31:0]};
      load_pkg::OP_LH, load_pkg::OP_LHU:
        result_o = {{(load_pkg::XLEN-16){sign_bit}}, shifted[15:0]};
      load_pkg::OP_LB, load_pkg::OP_LBU:
        result_o = {{(load_pkg::XLEN-8){sign_bit}}, shifted[7:0]};
      // LD passes the full doubleword
      default:
        result_o = shifted;
    endcase
  end

endmodule

//--- hw/load_unit.sv
/*
  Load path of the load/store unit, one load accepted at a time.
  Index goes out in the request cycle, tag one cycle after the grant.
  Up to four loads outstanding, responses may return in any order.
  The result has no ready, so the consumer must take valid_o at once.
*/
module load_unit (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // issue side
  input  logic                  flush_i,
  input  logic                  valid_i,
  input  load_pkg::addr_t       vaddr_i,
  input  load_pkg::load_op_t    op_i,
  input  load_pkg::trans_id_t   trans_id_i,
  output logic                  pop_ld_o,
  // store address check
  output load_pkg::index_t      page_offset_o,
  input  logic                  page_offset_matches_i,
  // cache request
  output logic                  data_req_o,
  input  logic                  data_gnt_i,
  output load_pkg::index_t      addr_index_o,
  output load_pkg::tag_t        addr_tag_o,
  output load_pkg::size_t       data_size_o,
  output load_pkg::ldbuf_id_t   data_id_o,
  output logic                  tag_valid_o,
  output logic                  kill_req_o,
  // cache response
  input  logic                  data_rvalid_i,
  input  load_pkg::ldbuf_id_t   data_rid_i,
  input  load_pkg::xlen_t       data_rdata_i,
  // result
  output logic                  valid_o,
  output load_pkg::trans_id_t   trans_id_o,
  output load_pkg::xlen_t       result_o
);

  logic                ldbuf_full;
  logic                ldbuf_we;
  load_pkg::offset_t   rd_offset;
  load_pkg::load_op_t  rd_op;

  // page offset for the store unit, no translation in between
  assign page_offset_o = vaddr_i[load_pkg::INDEX_W-1:0];

  // ----------------------------------------
  // request side
  // ----------------------------------------
  load_ctrl u_ctrl (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .valid_i               (valid_i),
    .vaddr_i               (vaddr_i),
    .op_i                  (op_i),
    .page_offset_matches_i (page_offset_matches_i),
    .data_gnt_i            (data_gnt_i),
    .ldbuf_full_i          (ldbuf_full),
    .data_req_o            (data_req_o),
    .addr_index_o          (addr_index_o),
    .data_size_o           (data_size_o),
    .addr_tag_o            (addr_tag_o),
    .tag_valid_o           (tag_valid_o),
    .kill_req_o            (kill_req_o),
    .pop_ld_o              (pop_ld_o),
    .ldbuf_we_o            (ldbuf_we)
  );

  // ----------------------------------------
  // outstanding loads
  // ----------------------------------------
  // free slot index doubles as the cache request id
  load_buffer u_buf (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .we_i        (ldbuf_we),
    .trans_id_i  (trans_id_i),
    .offset_i    (vaddr_i[load_pkg::OFFSET_W-1:0]),
    .op_i        (op_i),
    .rvalid_i    (data_rvalid_i),
    .rid_i       (data_rid_i),
    .full_o      (ldbuf_full),
    .wid_o       (data_id_o),
    .valid_o     (valid_o),
    .trans_id_o  (trans_id_o),
    .rd_offset_o (rd_offset),
    .rd_op_o     (rd_op)
  );

  // ----------------------------------------
  // result realign and extend
  // ----------------------------------------
  load_align u_align (
    .rdata_i  (data_rdata_i),
    .offset_i (rd_offset),
    .op_i     (rd_op),
    .result_o (result_o)
  );

endmodule

//--- tb/dcache_model.sv
/*
  Behavioral data cache port for the load unit testbench.
  Grant delay and response latency come from an 8-bit Galois LFSR, seed 48.
  Responses may return out of order, one per cycle, at least a cycle late.
  hold_i keeps every response back while latencies keep counting down.
  Read data depends only on the request index, kill_req is ignored.
*/
module dcache_model (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 hold_i,
  // request side
  input  logic                 data_req_i,
  input  load_pkg::index_t     addr_index_i,
  input  load_pkg::ldbuf_id_t  data_id_i,
  output logic                 data_gnt_o,
  // response side
  output logic                 data_rvalid_o,
  output load_pkg::ldbuf_id_t  data_rid_o,
  output load_pkg::xlen_t      data_rdata_o
);

  logic [7:0]           lfsr;
  int unsigned          gnt_wait;

  // requests granted but not yet answered
  load_pkg::ldbuf_id_t  pend_id  [$];
  load_pkg::index_t     pend_idx [$];
  int unsigned          pend_lat [$];

  // x^8 + x^6 + x^5 + x^4 + 1, shifting right
  function automatic logic [7:0] galois_step(logic [7:0] s);
    return {1'b0, s[7:1]} ^ (s[0] ? 8'hB8 : 8'h00);
  endfunction

  // one LFSR step per random bit
  function automatic int unsigned take_bits(int unsigned n);
    int unsigned v;
    v = 0;
    for (int unsigned i = 0; i < n; i++) begin
      v    = (v << 1) | int'(lfsr[0]);
      lfsr = galois_step(lfsr);
    end
    return v;
  endfunction

  // byte k holds idx[4:0]*8 + k, odd bytes get 0x80 added on top
  function automatic load_pkg::xlen_t index_data(load_pkg::index_t idx);
    load_pkg::xlen_t d;
    logic [7:0]      b;
    d = '0;
    for (int k = 0; k < 8; k++) begin
      b = 8'(int'(idx[4:0]) * 8 + k);
      if (k % 2 == 1) begin
        b = b + 8'h80;
      end
      d[k*8 +: 8] = b;
    end
    return d;
  endfunction

  // ----------------------------------------
  // grant and response sequencing
  // ----------------------------------------
  always @(posedge clk_i or negedge rst_ni) begin : p_cache
    int unsigned hit;
    if (!rst_ni) begin
      lfsr     = 8'd48;
      gnt_wait = 0;
      pend_id.delete();
      pend_idx.delete();
      pend_lat.delete();
      data_gnt_o    <= 1'b0;
      data_rvalid_o <= 1'b0;
      data_rid_o    <= '0;
      data_rdata_o  <= '0;
    end else begin
      // answer before taking new work, so latency is at least one cycle
      data_rvalid_o <= 1'b0;
      hit = pend_lat.size();
      for (int i = 0; i < pend_lat.size(); i++) begin
        if (!hold_i && hit == pend_lat.size() && pend_lat[i] == 0) begin
          hit = i;
        end
      end
      for (int i = 0; i < pend_lat.size(); i++) begin
        if (pend_lat[i] > 0) begin
          pend_lat[i]--;
        end
      end
      if (hit < pend_lat.size()) begin
        data_rvalid_o <= 1'b1;
        data_rid_o    <= pend_id[hit];
        data_rdata_o  <= index_data(pend_idx[hit]);
        pend_id.delete(hit);
        pend_idx.delete(hit);
        pend_lat.delete(hit);
      end

      // granted request, draw latency and the next grant gap
      if (data_req_i && data_gnt_o) begin
        pend_id.push_back(data_id_i);
        pend_idx.push_back(addr_index_i);
        pend_lat.push_back(take_bits(3));
        gnt_wait = take_bits(2);
        data_gnt_o <= (gnt_wait == 0);
      end else if (!data_gnt_o) begin
        if (gnt_wait == 0) begin
          data_gnt_o <= 1'b1;
        end else begin
          gnt_wait--;
        end
      end
    end
  end

endmodule

//--- tb/tb_load_unit.sv
/*
  Testbench for the load unit, driven from a stimulus table.
  Inputs change 2 units after the rising edge, outputs are sampled on the
  falling edge. Expected results come from the cache data rule and the
  extension rules of each opcode. Trans ids of loads in flight must differ.
*/
module tb_load_unit;

  localparam int        TIMEOUT = 200;
  // row flags
  localparam logic [4:0] F_WAIT  = 5'b00001;
  localparam logic [4:0] F_STALL = 5'b00010;
  localparam logic [4:0] F_HOLD  = 5'b00100;
  localparam logic [4:0] F_BLOCK = 5'b01000;
  localparam logic [4:0] F_FLUSH = 5'b10000;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 flush_i;
  logic                 valid_i;
  load_pkg::addr_t      vaddr_i;
  load_pkg::load_op_t   op_i;
  load_pkg::trans_id_t  trans_id_i;
  logic                 page_offset_matches_i;
  logic                 hold;
  logic                 pop_ld_o;
  load_pkg::index_t     page_offset_o;
  logic                 data_req_o;
  logic                 data_gnt;
  load_pkg::index_t     addr_index_o;
  load_pkg::tag_t       addr_tag_o;
  load_pkg::size_t      data_size_o;
  load_pkg::ldbuf_id_t  data_id_o;
  logic                 tag_valid_o;
  logic                 kill_req_o;
  logic                 data_rvalid;
  load_pkg::ldbuf_id_t  data_rid;
  load_pkg::xlen_t      data_rdata;
  logic                 valid_o;
  load_pkg::trans_id_t  trans_id_o;
  load_pkg::xlen_t      result_o;

  // stimulus table
  string                row_name  [$];
  load_pkg::addr_t      row_addr  [$];
  load_pkg::load_op_t   row_op    [$];
  load_pkg::trans_id_t  row_tid   [$];
  logic [4:0]           row_flags [$];

  // scoreboard, indexed by trans id
  logic [7:0]           pending = '0;
  load_pkg::xlen_t      exp_res  [8];
  string                exp_name [8];
  int                   err_mark [8];
  load_pkg::trans_id_t  rid_tid  [4];

  int  errors = 0;
  int  tests_run = 0;
  int  tests_failed = 0;
  int  pop_count = 0;
  int  issued = 0;
  bit  timed_out = 0;
  bit  tag_due = 0;
  load_pkg::tag_t tag_exp;

  load_unit uut (
    .clk_i (clk_i), .rst_ni (rst_ni), .flush_i (flush_i),
    .valid_i (valid_i), .vaddr_i (vaddr_i), .op_i (op_i),
    .trans_id_i (trans_id_i), .pop_ld_o (pop_ld_o),
    .page_offset_o (page_offset_o), .page_offset_matches_i (page_offset_matches_i),
    .data_req_o (data_req_o), .data_gnt_i (data_gnt),
    .addr_index_o (addr_index_o), .addr_tag_o (addr_tag_o),
    .data_size_o (data_size_o), .data_id_o (data_id_o),
    .tag_valid_o (tag_valid_o), .kill_req_o (kill_req_o),
    .data_rvalid_i (data_rvalid), .data_rid_i (data_rid), .data_rdata_i (data_rdata),
    .valid_o (valid_o), .trans_id_o (trans_id_o), .result_o (result_o)
  );

  dcache_model dcache (
    .clk_i (clk_i), .rst_ni (rst_ni), .hold_i (hold),
    .data_req_i (data_req_o), .addr_index_i (addr_index_o), .data_id_i (data_id_o),
    .data_gnt_o (data_gnt), .data_rvalid_o (data_rvalid),
    .data_rid_o (data_rid), .data_rdata_o (data_rdata)
  );

  always #20 clk_i = ~clk_i;

  // ----------------------------------------
  // expected values
  // ----------------------------------------
  // doubleword the cache returns for an index
  function automatic load_pkg::xlen_t cache_dword(load_pkg::index_t idx);
    load_pkg::xlen_t d;
    for (int k = 0; k < 8; k++) begin
      d[k*8 +: 8] = 8'(int'(idx[4:0]) * 8 + k + ((k % 2 == 1) ? 128 : 0));
    end
    return d;
  endfunction

  // field at the byte offset, extended from its own top bit
  function automatic load_pkg::xlen_t expected_result(load_pkg::addr_t a,
                                                      load_pkg::load_op_t op);
    load_pkg::xlen_t d;
    d = cache_dword(a[load_pkg::INDEX_W-1:0]) >> (int'(a[2:0]) * 8);
    case (op)
      load_pkg::OP_LW:  return {{32{d[31]}}, d[31:0]};
      load_pkg::OP_LWU: return {32'd0, d[31:0]};
      load_pkg::OP_LH:  return {{48{d[15]}}, d[15:0]};
      load_pkg::OP_LHU: return {48'd0, d[15:0]};
      load_pkg::OP_LB:  return {{56{d[7]}}, d[7:0]};
      load_pkg::OP_LBU: return {56'd0, d[7:0]};
      default:          return d;
    endcase
  endfunction

  // access size is log2 of the bytes the opcode reads
  function automatic load_pkg::size_t access_size(load_pkg::load_op_t op);
    int              nbytes;
    load_pkg::size_t s;
    case (op)
      load_pkg::OP_LD:                   nbytes = 8;
      load_pkg::OP_LW, load_pkg::OP_LWU: nbytes = 4;
      load_pkg::OP_LH, load_pkg::OP_LHU: nbytes = 2;
      default:                           nbytes = 1;
    endcase
    s = $clog2(nbytes);
    return s;
  endfunction

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_result(string name, load_pkg::xlen_t act, load_pkg::xlen_t exp);
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_id(string name, load_pkg::trans_id_t act,
                          load_pkg::trans_id_t exp);
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s trans id: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_tag(string name, load_pkg::tag_t act, load_pkg::tag_t exp);
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_index(string name, load_pkg::index_t act, load_pkg::index_t exp);
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_size(string name, load_pkg::size_t act, load_pkg::size_t exp);
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_flag(string name, bit act, bit exp);
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %0b, actual %0b", name, exp, act);
    end
  endtask

  // ----------------------------------------
  // monitor
  // ----------------------------------------
  task automatic collect_result();
    load_pkg::trans_id_t id;
    id = rid_tid[data_rid];
    if (!pending[id]) begin
      errors++;
      $display("valid_o for request id %0d while no load waits for it", data_rid);
    end else begin
      check_id(exp_name[id], trans_id_o, id);
      check_result(exp_name[id], result_o, exp_res[id]);
      pending[id] = 1'b0;
      tests_run++;
      if (errors != err_mark[id]) begin
        tests_failed++;
        $display("%s: fail", exp_name[id]);
      end else begin
        $display("%s: pass", exp_name[id]);
      end
    end
  endtask

  always @(negedge clk_i) begin
    if (rst_ni) begin
      // tag phase follows every grant by one cycle
      if (tag_due) begin
        check_flag("tag_valid_o after grant", tag_valid_o, 1'b1);
        check_tag("addr_tag_o after grant", addr_tag_o, tag_exp);
      end
      tag_due = data_req_o && data_gnt;
      tag_exp = vaddr_i[load_pkg::ADDR_W-1:load_pkg::INDEX_W];
      if (pop_ld_o) begin
        pop_count++;
      end
      // store unit sees the low address bits of the pending load
      if (valid_i) begin
        check_index("page_offset_o", page_offset_o, vaddr_i[load_pkg::INDEX_W-1:0]);
      end
      if (data_req_o && data_gnt) begin
        rid_tid[data_id_o] = trans_id_i;
        check_index("addr_index_o", addr_index_o, vaddr_i[load_pkg::INDEX_W-1:0]);
        check_size("data_size_o", data_size_o, access_size(op_i));
      end
      if (valid_o) begin
        collect_result();
      end
    end
  end

  // ----------------------------------------
  // table and row handling
  // ----------------------------------------
  task automatic add_row(string name, load_pkg::addr_t a, load_pkg::load_op_t op,
                         load_pkg::trans_id_t tid, logic [4:0] f);
    row_name.push_back(name);
    row_addr.push_back(a);
    row_op.push_back(op);
    row_tid.push_back(tid);
    row_flags.push_back(f);
  endtask

  task automatic build_table();
    // every opcode at legal offsets, one at a time
    add_row("ld_off0",   32'h1234_5000, load_pkg::OP_LD,  3'd0, F_WAIT);
    add_row("lw_off0",   32'h0000_1008, load_pkg::OP_LW,  3'd1, F_WAIT);
    add_row("lw_off4",   32'h0000_10AC, load_pkg::OP_LW,  3'd2, F_WAIT);
    add_row("lwu_off4",  32'hABCD_E01C, load_pkg::OP_LWU, 3'd3, F_WAIT);
    add_row("lh_off2",   32'h0000_3002, load_pkg::OP_LH,  3'd4, F_WAIT);
    add_row("lh_off6",   32'h0000_2F16, load_pkg::OP_LH,  3'd5, F_WAIT);
    add_row("lhu_off6",  32'h7777_700E, load_pkg::OP_LHU, 3'd6, F_WAIT);
    add_row("lhu_off0",  32'h0000_8090, load_pkg::OP_LHU, 3'd7, F_WAIT);
    add_row("lb_off1",   32'h0000_4001, load_pkg::OP_LB,  3'd0, F_WAIT);
    add_row("lb_off7",   32'h0000_401F, load_pkg::OP_LB,  3'd1, F_WAIT);
    add_row("lbu_off3",  32'h0000_5013, load_pkg::OP_LBU, 3'd2, F_WAIT);
    add_row("lbu_off5",  32'hFFFF_F0FD, load_pkg::OP_LBU, 3'd3, F_WAIT);
    // store offset conflict
    add_row("stall_lw",  32'h0000_6024, load_pkg::OP_LW,  3'd4, F_WAIT | F_STALL);
    add_row("stall_lbu", 32'h0000_6031, load_pkg::OP_LBU, 3'd5, F_WAIT | F_STALL);
    // several in flight, answered out of order
    add_row("ooo_ld",    32'h0000_7000, load_pkg::OP_LD,  3'd0, 5'b0);
    add_row("ooo_lw",    32'h0000_7104, load_pkg::OP_LW,  3'd1, 5'b0);
    add_row("ooo_lh",    32'h0000_720A, load_pkg::OP_LH,  3'd2, 5'b0);
    add_row("ooo_lb",    32'h0000_7307, load_pkg::OP_LB,  3'd3, F_WAIT);
    // buffer full while responses are held
    add_row("full_lwu",  32'h00A0_0044, load_pkg::OP_LWU, 3'd4, F_HOLD);
    add_row("full_lhu",  32'h00A0_0052, load_pkg::OP_LHU, 3'd5, F_HOLD);
    add_row("full_lb",   32'h00A0_0063, load_pkg::OP_LB,  3'd6, F_HOLD);
    add_row("full_ld",   32'h00A0_0078, load_pkg::OP_LD,  3'd7, F_HOLD);
    add_row("full_lbu",  32'h00A0_0089, load_pkg::OP_LBU, 3'd0, F_WAIT | F_BLOCK);
    // flush with two loads outstanding, then normal loads
    add_row("fl_lw",     32'h00B0_0104, load_pkg::OP_LW,  3'd5, F_HOLD);
    add_row("fl_lh",     32'h00B0_0112, load_pkg::OP_LH,  3'd6, F_HOLD);
    add_row("flush",     32'h0000_0000, load_pkg::OP_LD,  3'd0, F_FLUSH);
    add_row("post_ld",   32'h00C0_0200, load_pkg::OP_LD,  3'd1, F_WAIT);
    add_row("post_lb",   32'h00C0_0215, load_pkg::OP_LB,  3'd2, F_WAIT);
  endtask

  task automatic wait_result(load_pkg::trans_id_t id, string name);
    int t;
    t = 0;
    while (pending[id] && t < TIMEOUT) begin
      @(negedge clk_i);
      t++;
    end
    if (pending[id]) begin
      timed_out = 1'b1;
      $display("%s: no valid_o before the timeout", name);
    end
  endtask

  task automatic wait_drain(string name);
    int t;
    t = 0;
    while (pending != '0 && t < TIMEOUT) begin
      @(negedge clk_i);
      t++;
    end
    if (pending != '0) begin
      timed_out = 1'b1;
      $display("%s: loads still outstanding after the timeout", name);
    end
  endtask

  task automatic issue_load(int r);
    int                  t;
    load_pkg::trans_id_t id;
    string               name;
    id   = row_tid[r];
    name = row_name[r];
    @(posedge clk_i);
    #2;
    valid_i               = 1'b1;
    vaddr_i               = row_addr[r];
    op_i                  = row_op[r];
    trans_id_i            = id;
    page_offset_matches_i = (row_flags[r] & F_STALL) != 0;
    err_mark[id]          = errors;
    // no request while a store matches, no pop while the buffer is full
    if ((row_flags[r] & (F_STALL | F_BLOCK)) != 0) begin
      repeat (6) begin
        @(negedge clk_i);
        check_flag({name, " data_req_o"}, data_req_o, 1'b0);
        check_flag({name, " pop_ld_o"}, pop_ld_o, 1'b0);
      end
      @(posedge clk_i);
      #2;
      page_offset_matches_i = 1'b0;
      hold                  = 1'b0;
    end
    t = 0;
    @(negedge clk_i);
    while (!pop_ld_o && t < TIMEOUT) begin
      @(negedge clk_i);
      t++;
    end
    if (!pop_ld_o) begin
      timed_out = 1'b1;
      $display("%s: no pop_ld_o before the timeout", name);
      return;
    end
    exp_name[id] = name;
    exp_res[id]  = expected_result(row_addr[r], row_op[r]);
    pending[id]  = 1'b1;
    issued++;
    @(posedge clk_i);
    #2;
    valid_i = 1'b0;
    if ((row_flags[r] & F_WAIT) != 0) begin
      wait_result(id, name);
    end
  endtask

  // flush pulse, the loads in flight must never report
  task automatic apply_flush(string name);
    int err0;
    err0 = errors;
    @(posedge clk_i);
    #2;
    flush_i = 1'b1;
    @(posedge clk_i);
    #2;
    flush_i = 1'b0;
    @(negedge clk_i);
    check_flag({name, " kill_req_o"}, kill_req_o, 1'b1);
    check_flag({name, " tag_valid_o"}, tag_valid_o, 1'b1);
    for (int i = 0; i < 8; i++) begin
      if (pending[i]) begin
        pending[i] = 1'b0;
        tests_run++;
        $display("%s: flushed, no result expected", exp_name[i]);
      end
    end
    tests_run++;
    if (errors != err0) begin
      tests_failed++;
      $display("%s: fail", name);
    end else begin
      $display("%s: pass", name);
    end
    @(posedge clk_i);
    #2;
    hold = 1'b0;
  endtask

  task automatic run_row(int r);
    if ((row_flags[r] & F_FLUSH) != 0) begin
      apply_flush(row_name[r]);
    end else begin
      // start holding only once the buffer has drained
      if ((row_flags[r] & F_HOLD) != 0 && !hold) begin
        wait_drain(row_name[r]);
        @(posedge clk_i);
        #2;
        hold = 1'b1;
      end
      if (!timed_out) begin
        issue_load(r);
      end
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    int r;
    clk_i                 = 1'b0;
    rst_ni                = 1'b0;
    flush_i               = 1'b0;
    valid_i               = 1'b0;
    vaddr_i               = '0;
    op_i                  = load_pkg::OP_LD;
    trans_id_i            = '0;
    page_offset_matches_i = 1'b0;
    hold                  = 1'b0;
    build_table();
    repeat (8) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    for (r = 0; r < row_name.size() && !timed_out; r++) begin
      run_row(r);
    end
    if (!timed_out) begin
      wait_drain("end of run");
    end
    // exactly one pop per accepted load
    if (pop_count != issued) begin
      errors++;
      $display("pop_ld_o pulsed %0d times for %0d loads", pop_count, issued);
    end

    $display("tests run %0d, tests failed %0d, check errors %0d",
             tests_run, tests_failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- load_unit.f
hw/load_pkg.sv
hw/load_ctrl.sv
hw/load_buffer.sv
hw/load_align.sv
hw/load_unit.sv
tb/dcache_model.sv
tb/tb_load_unit.sv
